// File: sim/fpAdder_input.txt
// columns: op (0 add, 1 subtract), operand A, operand B, expected result, expected status
// all hex; status bit 1 is invalid, bit 0 is overflow
0 3F800000 3F800000 40000000 0
0 3FC00000 40200000 40800000 0
0 3FFFFFFF 3F800000 403FFFFF 0
0 3F800000 33800000 3F800000 0
1 3F800000 2B800000 3F7FFFFF 0
1 3F800001 3F800000 34000000 0
1 3F800000 3F800001 B4000000 0
1 40490FDB 40490FDB 00000000 0
0 7F800001 3F800000 7FC00000 2
1 3F800000 FFC12345 7FC00000 2
1 7F800000 7F800000 7FC00000 2
0 7F800000 7F800000 7F800000 0
1 3F800000 7F800000 FF800000 0
0 FF800000 42000000 FF800000 0
0 00000000 40400000 40400000 0
1 C0A00000 00000000 C0A00000 0
1 00000000 40400000 C0400000 0
0 80000000 80000000 80000000 0
1 80000000 00000000 80000000 0
0 80000000 00000000 00000000 0
0 7F7FFFFF 7F7FFFFF 7F800000 1
1 FF7FFFFF 7F7FFFFF FF800000 1
0 00400000 00800000 00C00000 0
0 01000000 00400000 01200000 0
1 00C00000 00800000 00000000 0
1 80C00000 80800000 80000000 0

// File: sim.f
rtl/fpFormatPkg.sv
rtl/fpOpPkg.sv
rtl/fpBus.sv
rtl/fpUnpack.sv
rtl/alignment.sv
rtl/mantissaAddNorm.sv
rtl/fpPack.sv
rtl/fpAdder.sv
sim/fpAdder_checker.sv
sim/fpAdderTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = fpAdderTb
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)

// File: sim/fpAdderTb.sv
// adder testbench that reads vectors from a data file and checks them in issue order
module fpAdderTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int maxVectors      = 64;
    localparam int wordsPerVector  = 5;
    localparam int clkPeriod       = 4;
    localparam int cyclesPerVector = 5;
    localparam logic [31:0] emptyWord = 32'hFFFF_FFFF;

    logic                clk;
    logic                arstN;
    logic                inValid;
    fpOpPkg::fpOpT       op;
    fpFormatPkg::fpWordT operandA;
    fpFormatPkg::fpWordT operandB;
    logic                outValid;
    fpFormatPkg::fpWordT result;
    fpOpPkg::fpStatusT   status;

    logic [31:0]         vecMem [0:maxVectors*wordsPerVector-1];
    fpFormatPkg::fpWordT expResultQ[$];
    fpOpPkg::fpStatusT   expStatusQ[$];
    int                  vecIdxQ[$];
    int                  numVectors = 0;
    int                  checkedCount = 0;
    int                  errorCount = 0;
    logic                loaded = 1'b0;
    logic [31:0]         rngState = 32'd31;

    fpAdder #(.guardBits(8)) UUT (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .outValid (outValid),
        .result   (result),
        .status   (status)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // ====================
    // compare
    // ====================

    task automatic checkResult(input int idx, input fpFormatPkg::fpWordT got,
                               input fpFormatPkg::fpWordT expected, inout logic ok);
        if (got !== expected)
        begin
            $display("ERR %0t: vector %0d result %08h, expected %08h", $time, idx, got, expected);
            errorCount++;
            ok = 1'b0;
        end
    endtask

    task automatic checkStatus(input int idx, input fpOpPkg::fpStatusT got,
                               input fpOpPkg::fpStatusT expected, inout logic ok);
        if (got !== expected)
        begin
            $display("ERR %0t: vector %0d status %b, expected %b", $time, idx, got, expected);
            errorCount++;
            ok = 1'b0;
        end
    endtask

    task automatic checkNext();
        int                  idx;
        fpFormatPkg::fpWordT expResult;
        fpOpPkg::fpStatusT   expStatus;
        logic                ok;
        idx       = vecIdxQ.pop_front();
        expResult = expResultQ.pop_front();
        expStatus = expStatusQ.pop_front();
        ok        = 1'b1;
        checkResult(idx, result, expResult, ok);
        checkStatus(idx, status, expStatus, ok);
        checkedCount++;
        if (ok)
            $display("vector %0d: result %08h status %b ok", idx, result, status);
        else
            $display("vector %0d: mismatch", idx);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (arstN && outValid)
        begin
            if (vecIdxQ.size() == 0)
            begin
                $display("a result came out at %0t with no vector pending", $time);
                errorCount++;
            end
            else
                checkNext();
        end
    end

    // ====================
    // stimulus
    // ====================

    initial
    begin
        int idle;
        int base;
        arstN    = 1'b0;
        inValid  = 1'b0;
        op       = '0;
        operandA = '0;
        operandB = '0;
        for (int i = 0; i < maxVectors * wordsPerVector; i++)
            vecMem[i] = emptyWord;
        $readmemh("sim/fpAdder_input.txt", vecMem);
        while (numVectors < maxVectors && vecMem[numVectors * wordsPerVector] != emptyWord)
            numVectors++;
        loaded = 1'b1;

        repeat (4) @(posedge clk);
        #1 arstN = 1'b1;
        @(posedge clk);
        #1;

        for (int v = 0; v < numVectors; v++)
        begin
            base     = v * wordsPerVector;
            inValid  = 1'b1;
            op       = vecMem[base][0:0];
            operandA = vecMem[base + 1];
            operandB = vecMem[base + 2];
            expResultQ.push_back(vecMem[base + 3]);
            expStatusQ.push_back(vecMem[base + 4][1:0]);
            vecIdxQ.push_back(v);
            @(posedge clk);
            #1;
            rngState = xorshift(rngState);
            idle     = int'(rngState % 3);
            // with no idle cycle the next vector follows on the very next edge
            if (idle != 0 || v == numVectors - 1)
                inValid = 1'b0;
            repeat (idle)
            begin
                @(posedge clk);
                #1;
            end
        end

        // results are due two edges after the last input
        for (int w = 0; w < 6 && vecIdxQ.size() != 0; w++)
            @(posedge clk);
        repeat (2) @(posedge clk);

        if (numVectors == 0)
        begin
            $display("no vectors were read from the data file");
            errorCount++;
        end
        if (vecIdxQ.size() != 0)
        begin
            $display("%0d vectors never produced a result", vecIdxQ.size());
            errorCount += vecIdxQ.size();
        end
        $display("vectors %0d, checked %0d, errors %0d", numVectors, checkedCount, errorCount);
        if (errorCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (loaded);
        #(numVectors * cyclesPerVector * clkPeriod + 200);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: sim/fpAdder_checker.sv
// assertions on adder output timing, reset behavior and the NaN encoding
module fpAdderChecker (
    input logic                clk,
    input logic                arstN,
    input logic                inValid,
    input logic                outValid,
    input fpFormatPkg::fpWordT result,
    input fpOpPkg::fpStatusT   status
);

    timeunit 1ns;
    timeprecision 100ps;

    resetQuiet: assert property (@(posedge clk) !arstN |-> !outValid)
        else $error("outValid high while in reset");

    // input register, then output register
    latency: assert property (@(posedge clk) disable iff (!arstN)
        outValid == $past(inValid, 2))
        else $error("outValid does not follow inValid by two cycles");

    nanEncoding: assert property (@(posedge clk) disable iff (!arstN)
        (outValid && status[fpOpPkg::statusInvalidBit]) |-> (result == fpFormatPkg::quietNan))
        else $error("invalid status without the quiet NaN result");

endmodule

bind fpAdder fpAdderChecker timingChecks (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result),
    .status   (status)
);

// File: rtl/fpAdder.sv
// single-precision add/subtract unit with two register stages around combinational align and add
module fpAdder #(
    parameter int guardBits = 8
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  fpOpPkg::fpOpT       op,
    input  fpFormatPkg::fpWordT operandA,
    input  fpFormatPkg::fpWordT operandB,
    output logic                outValid,
    output fpFormatPkg::fpWordT result,
    output fpOpPkg::fpStatusT   status
);

    fpBus   #(.guardBits(guardBits)) stageBus ();
    normBus #(.guardBits(guardBits)) packBus ();

    fpUnpack unpackStage (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (inValid),
        .op       (op),
        .operandA (operandA),
        .operandB (operandB),
        .bus      (stageBus)
    );

    alignment #(.guardBits(guardBits)) alignStage (
        .bus (stageBus)
    );

    mantissaAddNorm #(.guardBits(guardBits)) addNormStage (
        .bus  (stageBus),
        .norm (packBus)
    );

    fpPack packStage (
        .clk      (clk),
        .arstN    (arstN),
        .norm     (packBus),
        .outValid (outValid),
        .result   (result),
        .status   (status)
    );

endmodule

// File: rtl/fpPack.sv
// special-case select, overflow and flush handling, and the result register
module fpPack (
    input  logic                 clk,
    input  logic                 arstN,
    normBus.pack                 norm,
    output logic                 outValid,
    output fpFormatPkg::fpWordT  result,
    output fpOpPkg::fpStatusT    status
);

    fpFormatPkg::fpWordT nextResult;
    fpOpPkg::fpStatusT   nextStatus;
    fpFormatPkg::fpWordT wordA;
    fpFormatPkg::fpWordT wordB;

    // passthrough operands with subnormals flushed to a signed zero
    assign wordA = norm.Asub ? {norm.signA, 31'b0}
                             : {norm.signA, norm.exponentA, norm.mantissaA};
    assign wordB = norm.Bsub ? {norm.signB, 31'b0}
                             : {norm.signB, norm.exponentB, norm.mantissaB};

    always_comb
    begin
        nextStatus = '0;
        if (norm.bypass)
        begin
            if (norm.ANaN | norm.BNaN | (norm.Ainf & norm.Binf & (norm.signA != norm.signB)))
            begin
                nextResult = fpFormatPkg::quietNan;
                nextStatus[fpOpPkg::statusInvalidBit] = 1'b1;
            end
            else if (norm.Ainf)
                nextResult = {norm.signA, fpFormatPkg::expMax, 23'b0};
            else if (norm.Binf)
                nextResult = {norm.signB, fpFormatPkg::expMax, 23'b0};
            else if (norm.Azero & norm.Bzero)
                nextResult = {norm.signA & norm.signB, 31'b0};
            else if (norm.Azero)
                nextResult = wordB;
            else
                nextResult = wordA;
        end
        else if (norm.overflow)
        begin
            nextResult = {norm.sign, fpFormatPkg::expMax, 23'b0};
            nextStatus[fpOpPkg::statusOverflowBit] = 1'b1;
        end
        else if (norm.underflow)
            nextResult = {norm.sign, 31'b0};
        else
            nextResult = {norm.sign, norm.exponent, norm.mantissa};
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            outValid <= 1'b0;
        else
            outValid <= norm.valid;
    end

    always_ff @(posedge clk)
    begin
        result <= nextResult;
        status <= nextStatus;
    end

endmodule

// File: rtl/mantissaAddNorm.sv
// effective add or subtract of aligned mantissas, then leading-one normalization
module mantissaAddNorm #(
    parameter int guardBits = 8
) (
    fpBus.addNorm bus,
    normBus.norm  norm
);

    localparam int alignW = 24 + guardBits;
    localparam int leadW  = $clog2(alignW + 1);

    logic              aLarger;
    logic              sameSign;
    logic [alignW-1:0] bigM;
    logic [alignW-1:0] smallM;
    logic [alignW:0]   rawSum;
    logic [alignW:0]   normSum;
    logic [leadW-1:0]  leadPos;
    int                expCalc;

    assign sameSign = (bus.signA == bus.signB);

    // equal exponents fall back to a mantissa compare
    assign aLarger = bus.Aex | (~bus.Bex & (bus.alignedMantissaA >= bus.alignedMantissaB));
    assign bigM    = aLarger ? bus.alignedMantissaA : bus.alignedMantissaB;
    assign smallM  = aLarger ? bus.alignedMantissaB : bus.alignedMantissaA;

    // ====================
    // add / subtract
    // ====================

    always_comb
    begin
        if (sameSign)
            rawSum = {1'b0, bus.alignedMantissaA} + {1'b0, bus.alignedMantissaB};
        else
            // lost shift bits borrow one so the difference truncates toward zero
            rawSum = {1'b0, bigM} - {1'b0, smallM} - {{alignW{1'b0}}, bus.shiftOverflow};
    end

    // ====================
    // normalize
    // ====================

    always_comb
    begin
        leadPos = '0;
        for (int i = 0; i <= alignW; i++)
        begin
            if (rawSum[i])
                leadPos = leadW'(i);
        end
    end

    always_comb
    begin
        if (int'(leadPos) == alignW)
            normSum = rawSum >> 1;
        else
            normSum = rawSum << (alignW - 1 - int'(leadPos));
        expCalc = int'(bus.exponentOut) + int'(leadPos) - (alignW - 1);
    end

    assign norm.valid       = bus.valid;
    // exact cancellation is +0
    assign norm.sign        = sameSign ? bus.signA :
                              (rawSum == '0) ? 1'b0 : (aLarger ? bus.signA : bus.signB);
    assign norm.exponent    = expCalc[7:0];
    assign norm.significand = normSum[alignW-1:0];
    assign norm.overflow    = (expCalc >= int'(fpFormatPkg::expMax));
    assign norm.underflow   = (rawSum == '0) || (expCalc < 1);
    assign norm.bypass      = bus.bypassALU;

    // operands travel on for the special cases
    assign norm.signA     = bus.signA;
    assign norm.signB     = bus.signB;
    assign norm.exponentA = bus.exponentA;
    assign norm.exponentB = bus.exponentB;
    assign norm.mantissaA = bus.mantissaA;
    assign norm.mantissaB = bus.mantissaB;
    assign norm.Asub      = bus.Asub;
    assign norm.Bsub      = bus.Bsub;
    assign norm.ANaN      = bus.ANaN;
    assign norm.BNaN      = bus.BNaN;
    assign norm.Ainf      = bus.Ainf;
    assign norm.Binf      = bus.Binf;
    assign norm.Azero     = bus.Azero;
    assign norm.Bzero     = bus.Bzero;

endmodule

// File: rtl/alignment.sv
// exponent compare and right shift of the smaller mantissa onto the larger exponent
module alignment #(
    parameter int guardBits = 8
) (
    fpBus.align bus
);

    localparam int alignW = 24 + guardBits;

    fpFormatPkg::expT  exponentDifferential;
    logic [alignW-1:0] fullA;
    logic [alignW-1:0] fullB;
    logic [alignW-1:0] lostMask;

    // ====================
    // control
    // ====================

    assign bus.Aex = (bus.exponentA > bus.exponentB);
    assign bus.Bex = (bus.exponentA < bus.exponentB);

    // any special operand skips the arithmetic in the pack stage
    assign bus.bypassALU = bus.ANaN | bus.BNaN | bus.Ainf | bus.Binf | bus.Azero | bus.Bzero;

    // ====================
    // exponent
    // ====================

    assign bus.exponentOut = bus.Bex ? bus.exponentB : bus.exponentA;

    always_comb
    begin
        if (bus.Aex)
            exponentDifferential = bus.exponentA - bus.exponentB;
        else if (bus.Bex)
            exponentDifferential = bus.exponentB - bus.exponentA;
        else
            exponentDifferential = '0;
    end

    // ====================
    // mantissa
    // ====================

    // hidden bit is clear for subnormals, guard bits start at zero
    assign fullA = {~(bus.Asub | bus.Azero), bus.mantissaA, {guardBits{1'b0}}};
    assign fullB = {~(bus.Bsub | bus.Bzero), bus.mantissaB, {guardBits{1'b0}}};

    // low bits that fall off the end of a right shift by the difference
    assign lostMask = ~({alignW{1'b1}} << exponentDifferential);

    always_comb
    begin
        if (bus.Bex)
        begin
            bus.alignedMantissaA = fullA >> exponentDifferential;
            bus.alignedMantissaB = fullB;
            bus.shiftOverflow    = |(fullA & lostMask);
        end
        else
        begin
            // equal exponents land here with a zero shift
            bus.alignedMantissaA = fullA;
            bus.alignedMantissaB = fullB >> exponentDifferential;
            bus.shiftOverflow    = |(fullB & lostMask);
        end
    end

endmodule

// File: rtl/fpUnpack.sv
// input register stage that latches operands and splits them into classified fields
module fpUnpack (
    input  logic                clk,
    input  logic                arstN,
    input  logic                inValid,
    input  fpOpPkg::fpOpT       op,
    input  fpFormatPkg::fpWordT operandA,
    input  fpFormatPkg::fpWordT operandB,
    fpBus.unpack                bus
);

    fpFormatPkg::fpWordT wordA;
    fpFormatPkg::fpWordT wordB;
    fpOpPkg::fpOpT       opReg;
    logic                validReg;
    fpFormatPkg::expT    rawExpA;
    fpFormatPkg::expT    rawExpB;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            validReg <= 1'b0;
        else
            validReg <= inValid;
    end

    // operand words load only on a strobe
    always_ff @(posedge clk)
    begin
        if (inValid)
        begin
            wordA <= operandA;
            wordB <= operandB;
            opReg <= op;
        end
    end

    assign rawExpA = wordA[30:23];
    assign rawExpB = wordB[30:23];

    assign bus.valid = validReg;
    assign bus.signA = wordA[31];
    // subtract becomes an add of the negated B
    assign bus.signB = wordB[31] ^ (opReg == fpOpPkg::opSub);

    assign bus.mantissaA = wordA[22:0];
    assign bus.mantissaB = wordB[22:0];

    // exponent field 0 counts as 1 so the alignment distance is right
    assign bus.exponentA = (rawExpA == '0) ? 8'd1 : rawExpA;
    assign bus.exponentB = (rawExpB == '0) ? 8'd1 : rawExpB;

    // ====================
    // classification
    // ====================

    assign bus.Azero = (rawExpA == '0) && (wordA[22:0] == '0);
    assign bus.Bzero = (rawExpB == '0) && (wordB[22:0] == '0);
    assign bus.Asub  = (rawExpA == '0) && (wordA[22:0] != '0);
    assign bus.Bsub  = (rawExpB == '0) && (wordB[22:0] != '0);
    assign bus.Ainf  = (rawExpA == fpFormatPkg::expMax) && (wordA[22:0] == '0);
    assign bus.Binf  = (rawExpB == fpFormatPkg::expMax) && (wordB[22:0] == '0);
    assign bus.ANaN  = (rawExpA == fpFormatPkg::expMax) && (wordA[22:0] != '0);
    assign bus.BNaN  = (rawExpB == fpFormatPkg::expMax) && (wordB[22:0] != '0);

endmodule

// File: rtl/fpBus.sv
// stage links that carry operands to alignment and add and the normalized sum to pack
interface fpBus #(parameter int guardBits = 8);

    localparam int alignW = 24 + guardBits;

    logic                valid;
    logic                signA, signB;
    fpFormatPkg::expT    exponentA, exponentB;
    fpFormatPkg::fracT   mantissaA, mantissaB;
    logic                Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero;

    logic                Aex, Bex;
    fpFormatPkg::expT    exponentOut;
    logic [alignW-1:0]   alignedMantissaA, alignedMantissaB;
    logic                shiftOverflow;
    logic                bypassALU;

    modport unpack (output valid, signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                    Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero);

    modport align (input exponentA, exponentB, mantissaA, mantissaB,
                   Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero,
                   output Aex, Bex, exponentOut, alignedMantissaA, alignedMantissaB,
                   shiftOverflow, bypassALU);

    modport addNorm (input valid, signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                     Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero,
                     Aex, Bex, exponentOut, alignedMantissaA, alignedMantissaB,
                     shiftOverflow, bypassALU);

endinterface

interface normBus #(parameter int guardBits = 8);

    logic                    valid;
    logic                    sign;
    fpFormatPkg::expT        exponent;
    // normalized significand with the hidden bit on top and guard bits at the bottom
    logic [23+guardBits:0]   significand;
    fpFormatPkg::fracT       mantissa;
    logic                    overflow, underflow, bypass;

    // raw operands for the special-case paths
    logic                    signA, signB;
    fpFormatPkg::expT        exponentA, exponentB;
    fpFormatPkg::fracT       mantissaA, mantissaB;
    logic                    Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero;

    // truncation drops the guard bits
    assign mantissa = significand[guardBits +: 23];

    modport norm (output valid, sign, exponent, significand, overflow, underflow, bypass,
                  signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                  Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero);

    modport pack (input valid, sign, exponent, mantissa, overflow, underflow, bypass,
                  signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                  Asub, Bsub, ANaN, BNaN, Ainf, Binf, Azero, Bzero);

endinterface

// File: rtl/fpOpPkg.sv
// adder operation codes and result status flags
package fpOpPkg;

    // ====================
    // operation
    // ====================

    typedef logic [0:0] fpOpT;

    localparam fpOpT opAdd = 1'b0;
    localparam fpOpT opSub = 1'b1;

    // ====================
    // status
    // ====================

    // bit 1 invalid, bit 0 overflow
    typedef logic [1:0] fpStatusT;

    localparam int statusInvalidBit = 1;
    localparam int statusOverflowBit = 0;

endpackage

// File: rtl/fpFormatPkg.sv
// IEEE single-precision number format with its field types and encoding constants
package fpFormatPkg;

    // ====================
    // field types
    // ====================

    // sign in bit 31 above the exponent in 30:23 and the fraction in 22:0
    typedef logic [31:0] fpWordT;

    typedef logic [7:0] expT;

    typedef logic [22:0] fracT;

    // ====================
    // encoding constants
    // ====================

    localparam expT expBias = 8'd127;

    // all-ones exponent marks infinity and NaN
    localparam expT expMax = 8'd255;

    localparam fpWordT quietNan = 32'h7FC0_0000;

endpackage
